/* cpu_consts.svh */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// datapath and register file
`define WORD_W      8
`define REG_COUNT   6
`define REG_AW      3

// program side
`define PC_W        8
`define PROG_DEPTH  256
`define INSTR_W     32

// data memory
`define RAM_AW      10
`define RAM_DEPTH   1024

////////////////////////////////////////////////////////////////////////////
// instruction word field positions from the top field down to the opcode
////////////////////////////////////////////////////////////////////////////
`define F_RAM_MSB   (`INSTR_W - 1)  // ram address [31:22]
`define F_RAM_LSB   22
`define F_IMM_LSB   14              // immediate / branch target [21:14]
`define F_OP1_LSB   11              // [13:11]
`define F_OP2_LSB   8               // [10:8]
`define F_OP3_LSB   5               // [7:5]
`define F_OPC_LSB   0               // [4:0]

`endif

/* cpu_pkg.sv */
`include "cpu_consts.svh"

package cpu_pkg;

	typedef logic [`WORD_W-1:0] word_t;
	typedef logic [`REG_AW-1:0] reg_addr_t;
	typedef logic [`PC_W-1:0]   pc_t;
	typedef logic [`RAM_AW-1:0] ram_addr_t;

	// gaps in the numbering are unused codes
	typedef enum logic [`F_OP3_LSB-`F_OPC_LSB-1:0]
	{
		op_eop   = 5'd0,
		op_move  = 5'd1,
		op_ldi   = 5'd2,
		op_add   = 5'd3,
		op_sub   = 5'd4,
		op_and   = 5'd5,
		op_or    = 5'd6,
		op_shl   = 5'd7,
		op_shr   = 5'd9,
		op_store = 5'd10,
		op_cmp   = 5'd11,
		op_bc    = 5'd12,
		op_bg    = 5'd13,
		op_bl    = 5'd14,
		op_bz    = 5'd15,
		op_bs    = 5'd17,
		op_jmp   = 5'd18,
		op_load  = 5'd22
	} opcode_t;

	typedef struct packed
	{
		logic [`F_RAM_MSB-`F_RAM_LSB:0]   ram_addr;
		logic [`F_RAM_LSB-`F_IMM_LSB-1:0] imm;      // also the branch target
		logic [`F_IMM_LSB-`F_OP1_LSB-1:0] op1;
		logic [`F_OP1_LSB-`F_OP2_LSB-1:0] op2;
		logic [`F_OP2_LSB-`F_OP3_LSB-1:0] op3;
		opcode_t                          opcode;
	} instr_t;

	typedef struct packed
	{
		logic carry;
		logic greater;
		logic shift;
		logic zero;
	} flags_t;

	typedef enum logic [2:0]
	{
		alu_add, alu_sub, alu_and, alu_or, alu_shl, alu_shr, alu_cmp
	} alu_op_t;

endpackage

/* dual_port_ram.sv */
`timescale 1ns/10ps
`include "cpu_consts.svh"

module dual_port_ram
#(
	parameter type elem_t = logic [`WORD_W-1:0],
	parameter int depth = `RAM_DEPTH
)
(
	input  logic              clock,
	input  logic [`RAM_AW-1:0] a_addr,
	input  logic              a_we,
	input  elem_t             a_wdata,
	output elem_t             a_rdata,
	input  logic [`RAM_AW-1:0] b_addr,
	input  logic              b_we,
	input  elem_t             b_wdata,
	output elem_t             b_rdata
);

	localparam int aw = $clog2(depth);

	elem_t mem [depth];
	logic [aw-1:0] a_idx;
	logic [aw-1:0] b_idx;

	assign a_idx = a_addr[aw-1:0];  // smaller memories ignore the top bits
	assign b_idx = b_addr[aw-1:0];

	always_ff @(posedge clock)
	begin
		if (a_we)
			mem[a_idx] <= a_wdata;
		if (b_we)
			mem[b_idx] <= b_wdata;
		a_rdata <= mem[a_idx];          // old data on a colliding read
		b_rdata <= mem[b_idx];
	end

	// core and host must never fight over one location
	a_no_write_collision: assert property (@(posedge clock)
		!(a_we && b_we && (a_idx == b_idx)))
	else
		$error("dual_port_ram: both ports write address %0d", a_idx);

endmodule

/* register_file.sv */
`timescale 1ns/10ps
`include "cpu_consts.svh"

module register_file
(
	input  logic              clock,
	input  logic              reset,
	input  cpu_pkg::reg_addr_t rd_a_addr,
	input  cpu_pkg::reg_addr_t rd_b_addr,
	input  cpu_pkg::reg_addr_t wr_addr,
	input  logic              we,
	input  cpu_pkg::word_t     wr_data,
	output cpu_pkg::word_t     rd_a_data,
	output cpu_pkg::word_t     rd_b_data
);

	import cpu_pkg::*;

	word_t regs [`REG_COUNT];

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end
		else if (we && (wr_addr < `REG_COUNT))
		begin
			regs[wr_addr] <= wr_data;
		end
	end

	// codes 6 and 7 have no register behind them
	always_comb
	begin
		rd_a_data = '0;
		rd_b_data = '0;
		if (rd_a_addr < `REG_COUNT)
			rd_a_data = regs[rd_a_addr];
		if (rd_b_addr < `REG_COUNT)
			rd_b_data = regs[rd_b_addr];
	end

	// a write to 6 or 7 means the program or decoder is wrong
	a_wr_addr_range: assert property (@(posedge clock) disable iff (reset)
		we |-> (wr_addr < `REG_COUNT))
	else
		$error("register_file: write to missing register %0d", wr_addr);

endmodule

/* alu.sv */
`timescale 1ns/10ps
`include "cpu_consts.svh"

module alu
(
	input  logic             clock,
	input  logic             reset,
	input  logic             start_clear,
	input  logic             alu_en,
	input  cpu_pkg::alu_op_t alu_op,
	input  cpu_pkg::word_t   a,
	input  cpu_pkg::word_t   b,
	output cpu_pkg::word_t   result,
	output cpu_pkg::flags_t  flags
);

	import cpu_pkg::*;

	logic [`WORD_W:0] sum;   // one extra bit for carry out
	logic [`WORD_W:0] diff;  // top bit is the borrow
	logic             res_zero;

	assign sum  = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} - {1'b0, b};

	always_comb
	begin
		case (alu_op)
			alu_add: result = sum[`WORD_W-1:0];
			alu_sub: result = diff[`WORD_W-1:0];
			alu_and: result = a & b;
			alu_or:  result = a | b;
			alu_shl: result = {a[`WORD_W-2:0], 1'b0};
			alu_shr: result = {1'b0, a[`WORD_W-1:1]};
			default: result = '0;     // cmp has no result
		endcase
	end

	assign res_zero = (result == '0);

	////////////////////////////////////////////////////////////////////////////
	// flag register where each op touches only the flags it owns
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock)
	begin
		if (reset || start_clear)
		begin
			flags <= '0;
		end
		else if (alu_en)
		begin
			case (alu_op)
				alu_add:
				begin
					flags.carry <= sum[`WORD_W];
					flags.zero  <= res_zero;
				end
				alu_sub:
				begin
					flags.carry <= diff[`WORD_W];
					flags.zero  <= res_zero;
				end
				alu_shl:
				begin
					flags.shift <= a[`WORD_W-1];  // bit pushed out the top
					flags.zero  <= res_zero;
				end
				alu_shr:
				begin
					flags.shift <= a[0];
					flags.zero  <= res_zero;
				end
				alu_cmp:
				begin
					flags.greater <= (a > b);
					flags.zero    <= (a == b);
				end
				default:
				begin
					flags.zero <= res_zero;    // and, or
				end
			endcase
		end
	end

endmodule

/* sequencer.sv */
`timescale 1ns/10ps

module sequencer
(
	input  logic               clock,
	input  logic               reset,
	input  logic               start,
	input  cpu_pkg::instr_t    instr,
	input  cpu_pkg::flags_t    flags,
	input  cpu_pkg::word_t     rd_a_data,
	input  cpu_pkg::word_t     alu_result,
	input  cpu_pkg::word_t     ram_rdata,
	output logic               busy,
	output logic               halted,
	output cpu_pkg::pc_t       pc,
	output cpu_pkg::reg_addr_t rd_a_addr,
	output cpu_pkg::reg_addr_t rd_b_addr,
	output cpu_pkg::reg_addr_t wr_addr,
	output logic               rf_we,
	output cpu_pkg::word_t     wr_data,
	output logic               alu_en,
	output cpu_pkg::alu_op_t   alu_op,
	output logic               start_clear,
	output cpu_pkg::ram_addr_t ram_addr,
	output logic               ram_we,
	output cpu_pkg::word_t     ram_wdata
);

	import cpu_pkg::*;

	typedef enum logic [1:0] {st_idle, st_fetch, st_execute, st_load_wait} state_t;

	state_t state;
	logic   take_branch;
	logic   op_valid;

	assign busy        = (state != st_idle);
	assign halted      = (state == st_idle);
	assign start_clear = (state == st_idle) && start;  // flags clear with the pc

	// operand fields go straight to the register file and data memory
	assign rd_a_addr = instr.op1;
	assign rd_b_addr = instr.op2;
	assign ram_addr  = instr.ram_addr;
	assign ram_wdata = rd_a_data;

	////////////////////////////////////////////////////////////////////////////
	// decode acts only in execute and load_wait
	////////////////////////////////////////////////////////////////////////////
	always_comb
	begin
		alu_op      = alu_add;
		alu_en      = 1'b0;
		rf_we       = 1'b0;
		wr_addr     = instr.op3;
		wr_data     = alu_result;
		ram_we      = 1'b0;
		take_branch = 1'b0;
		op_valid    = 1'b1;
		if (state == st_execute)
		begin
			case (instr.opcode)
				op_add, op_sub, op_and, op_or:
				begin
					alu_en = 1'b1;
					rf_we  = 1'b1;               // result to op3
					case (instr.opcode)
						op_sub:  alu_op = alu_sub;
						op_and:  alu_op = alu_and;
						op_or:   alu_op = alu_or;
						default: alu_op = alu_add;
					endcase
				end
				op_shl, op_shr:
				begin
					alu_op  = (instr.opcode == op_shl) ? alu_shl : alu_shr;
					alu_en  = 1'b1;
					rf_we   = 1'b1;
					wr_addr = instr.op1;         // shifts work in place
				end
				op_cmp:
				begin
					alu_op = alu_cmp;
					alu_en = 1'b1;
				end
				op_move:
				begin
					rf_we   = 1'b1;
					wr_addr = instr.op2;
					wr_data = rd_a_data;
				end
				op_ldi:
				begin
					rf_we   = 1'b1;
					wr_addr = instr.op1;
					wr_data = instr.imm;
				end
				op_store: ram_we = 1'b1;
				op_bc:    take_branch = flags.carry;
				op_bg:    take_branch = flags.greater;
				op_bl:    take_branch = !flags.greater && !flags.zero;
				op_bz:    take_branch = flags.zero;
				op_bs:    take_branch = flags.shift;
				op_jmp:   take_branch = 1'b1;
				op_eop, op_load:
				begin
					op_valid = 1'b1;             // handled by the state machine
				end
				default:  op_valid = 1'b0;      // runs as a no-op
			endcase
		end
		else if (state == st_load_wait)
		begin
			rf_we   = 1'b1;                      // ram data is now valid
			wr_addr = instr.op1;
			wr_data = ram_rdata;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// state machine and program counter
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= st_idle;
			pc    <= '0;
		end
		else
		begin
			case (state)
				st_idle:
				begin
					if (start)
					begin
						state <= st_fetch;
						pc    <= '0;
					end
				end
				st_fetch:
				begin
					state <= st_execute;         // instr valid next cycle
				end
				st_execute:
				begin
					if (instr.opcode == op_eop)
					begin
						state <= st_idle;
					end
					else if (instr.opcode == op_load)
					begin
						state <= st_load_wait;    // pc held so instr stays put
					end
					else
					begin
						state <= st_fetch;
						pc    <= take_branch ? instr.imm : pc + 1'b1;  // wraps at 255
					end
				end
				default:
				begin
					state <= st_fetch;
					pc    <= pc + 1'b1;
				end
			endcase
		end
	end

	// host may only start a halted core
	a_start_when_halted: assert property (@(posedge clock) disable iff (reset)
		busy |-> !start)
	else
		$error("sequencer: start raised while busy");

	// program memory content reaching execute must decode
	a_known_opcode: assert property (@(posedge clock) disable iff (reset)
		(state == st_execute) |-> op_valid)
	else
		$error("sequencer: undefined opcode %0d at pc %0d", instr.opcode, pc);

endmodule

/* cpu_top.sv */
`timescale 1ns/10ps
`include "cpu_consts.svh"

module cpu_top
(
	input  logic               clock,
	input  logic               reset,
	input  logic               start,
	output logic               busy,
	output logic               halted,
	input  logic               prog_we,
	input  cpu_pkg::pc_t       prog_addr,
	input  cpu_pkg::instr_t    prog_wdata,
	input  logic               host_we,
	input  cpu_pkg::ram_addr_t host_addr,
	input  cpu_pkg::word_t     host_wdata,
	output cpu_pkg::word_t     host_rdata
);

	import cpu_pkg::*;

	pc_t       pc;
	instr_t    instr;
	flags_t    flags;
	reg_addr_t rd_a_addr;
	reg_addr_t rd_b_addr;
	reg_addr_t wr_addr;
	logic      rf_we;
	word_t     wr_data;
	word_t     rd_a_data;
	word_t     rd_b_data;
	word_t     alu_result;
	logic      alu_en;
	alu_op_t   alu_op;
	logic      start_clear;
	ram_addr_t ram_addr;
	logic      ram_we;
	word_t     ram_wdata;
	word_t     ram_rdata;

	logic [`RAM_AW-1:0] prog_a_addr;
	logic [`RAM_AW-1:0] prog_b_addr;

	// program addresses widened to the shared memory port width
	assign prog_a_addr = {{(`RAM_AW-`PC_W){1'b0}}, pc};
	assign prog_b_addr = {{(`RAM_AW-`PC_W){1'b0}}, prog_addr};

	sequencer u_seq (.clock(clock), .reset(reset), .start(start), .instr(instr),
		.flags(flags), .rd_a_data(rd_a_data), .alu_result(alu_result),
		.ram_rdata(ram_rdata), .busy(busy), .halted(halted), .pc(pc),
		.rd_a_addr(rd_a_addr), .rd_b_addr(rd_b_addr), .wr_addr(wr_addr),
		.rf_we(rf_we), .wr_data(wr_data), .alu_en(alu_en), .alu_op(alu_op),
		.start_clear(start_clear), .ram_addr(ram_addr), .ram_we(ram_we),
		.ram_wdata(ram_wdata));

	register_file u_rf (.clock(clock), .reset(reset), .rd_a_addr(rd_a_addr),
		.rd_b_addr(rd_b_addr), .wr_addr(wr_addr), .we(rf_we), .wr_data(wr_data),
		.rd_a_data(rd_a_data), .rd_b_data(rd_b_data));

	alu u_alu (.clock(clock), .reset(reset), .start_clear(start_clear), .alu_en(alu_en),
		.alu_op(alu_op), .a(rd_a_data), .b(rd_b_data), .result(alu_result), .flags(flags));

	////////////////////////////////////////////////////////////////////////////
	// memories with port a for the core and port b for the host
	////////////////////////////////////////////////////////////////////////////
	dual_port_ram #(.elem_t(instr_t), .depth(`PROG_DEPTH)) u_prog_mem (.clock(clock),
		.a_addr(prog_a_addr), .a_we(1'b0), .a_wdata('0), .a_rdata(instr),
		.b_addr(prog_b_addr), .b_we(prog_we), .b_wdata(prog_wdata), .b_rdata());

	dual_port_ram #(.elem_t(word_t), .depth(`RAM_DEPTH)) u_data_mem (.clock(clock),
		.a_addr(ram_addr), .a_we(ram_we), .a_wdata(ram_wdata), .a_rdata(ram_rdata),
		.b_addr(host_addr), .b_we(host_we), .b_wdata(host_wdata), .b_rdata(host_rdata));

endmodule

/* cpu_tb.sv */
`timescale 1ns/10ps
`include "cpu_consts.svh"

module cpu_tb;

	import cpu_pkg::*;

	localparam int halt_timeout = 2000;
	localparam int step_limit   = 4000;

	logic      clock;
	logic      reset;
	logic      start;
	logic      busy;
	logic      halted;
	logic      prog_we;
	pc_t       prog_addr;
	instr_t    prog_wdata;
	logic      host_we;
	ram_addr_t host_addr;
	word_t     host_wdata;
	word_t     host_rdata;

	instr_t prog [`PROG_DEPTH];
	int     prog_len;
	word_t  m_regs [`REG_COUNT];     // model registers persist across runs like the core's
	word_t  m_ram [`RAM_DEPTH];
	bit     track [`RAM_DEPTH];      // addresses to peek after a run
	int     test_errors;
	int     tests_passed;
	int     tests_failed;
	bit     timed_out;

	cpu_top u_dut (.clock(clock), .reset(reset), .start(start), .busy(busy),
		.halted(halted), .prog_we(prog_we), .prog_addr(prog_addr),
		.prog_wdata(prog_wdata), .host_we(host_we), .host_addr(host_addr),
		.host_wdata(host_wdata), .host_rdata(host_rdata));

	always #5 clock = ~clock;

	////////////////////////////////////////////////////////////////////////////
	// program building
	////////////////////////////////////////////////////////////////////////////
	function automatic instr_t encode(opcode_t opc, int op1, int op2, int op3,
		int imm, int addr);
		instr_t ins;
		ins.opcode   = opc;
		ins.op1      = 3'(op1);
		ins.op2      = 3'(op2);
		ins.op3      = 3'(op3);
		ins.imm      = 8'(imm);
		ins.ram_addr = 10'(addr);
		return ins;
	endfunction

	task automatic emit(opcode_t opc, int op1, int op2, int op3, int imm, int addr);
		prog[prog_len] = encode(opc, op1, op2, op3, imm, addr);
		prog_len++;
	endtask

	// stores r4 to addr when the branch falls through and r5 when it is taken
	task automatic emit_branch_check(opcode_t opc, int addr);
		int base;
		base = prog_len;
		emit(opc, 0, 0, 0, base + 3, 0);
		emit(op_store, 4, 0, 0, 0, addr);
		emit(op_jmp, 0, 0, 0, base + 4, 0);
		emit(op_store, 5, 0, 0, 0, addr);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// instruction set reference model
	////////////////////////////////////////////////////////////////////////////
	function automatic void model_run();
		pc_t    pc;
		flags_t f;
		instr_t ins;
		word_t  a;
		word_t  b;
		word_t  r;
		bit     taken;
		pc = '0;
		f  = '0;                        // flags clear on every start
		for (int step = 0; step < step_limit; step++)
		begin
			ins   = prog[pc];
			a     = (ins.op1 < `REG_COUNT) ? m_regs[ins.op1] : 8'h00;
			b     = (ins.op2 < `REG_COUNT) ? m_regs[ins.op2] : 8'h00;
			taken = 1'b0;
			if (ins.opcode == op_eop)
				return;
			case (ins.opcode)
				op_add:
				begin
					r = a + b;
					f.carry = (int'(a) + int'(b)) > 255;
					f.zero = (r == 0);
					m_regs[ins.op3] = r;
				end
				op_sub:
				begin
					r = a - b;
					f.carry = (a < b);      // borrow
					f.zero = (r == 0);
					m_regs[ins.op3] = r;
				end
				op_and, op_or:
				begin
					r = (ins.opcode == op_and) ? (a & b) : (a | b);
					f.zero = (r == 0);
					m_regs[ins.op3] = r;
				end
				op_shl, op_shr:
				begin
					r = (ins.opcode == op_shl) ? (a << 1) : (a >> 1);
					f.shift = (ins.opcode == op_shl) ? a[7] : a[0];
					f.zero = (r == 0);
					m_regs[ins.op1] = r;    // in place
				end
				op_cmp:
				begin
					f.greater = (a > b);
					f.zero = (a == b);
				end
				op_move:  m_regs[ins.op2] = a;
				op_ldi:   m_regs[ins.op1] = ins.imm;
				op_store:
				begin
					m_ram[ins.ram_addr] = a;
					track[ins.ram_addr] = 1'b1;
				end
				op_load:  m_regs[ins.op1] = m_ram[ins.ram_addr];
				op_bc:    taken = f.carry;
				op_bg:    taken = f.greater;
				op_bl:    taken = !f.greater && !f.zero;
				op_bz:    taken = f.zero;
				op_bs:    taken = f.shift;
				op_jmp:   taken = 1'b1;
				default:  taken = 1'b0;
			endcase
			pc = taken ? ins.imm : pc_t'(pc + 1);
		end
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// host side tasks enter and leave on a falling edge
	////////////////////////////////////////////////////////////////////////////
	task automatic load_program();
		for (int i = 0; i < prog_len; i++)
		begin
			prog_we    = 1'b1;
			prog_addr  = pc_t'(i);
			prog_wdata = prog[i];
			@(negedge clock);
		end
		prog_we = 1'b0;
	endtask

	task automatic poke(int addr, word_t val);
		host_we    = 1'b1;
		host_addr  = ram_addr_t'(addr);
		host_wdata = val;
		@(negedge clock);
		host_we     = 1'b0;
		m_ram[addr] = val;
		track[addr] = 1'b1;             // host bytes must survive the run
	endtask

	task automatic peek(int addr, output word_t val);
		host_addr = ram_addr_t'(addr);
		@(negedge clock);
		val = host_rdata;
	endtask

	task automatic run(string name);
		int cycles;
		start = 1'b1;
		@(negedge clock);
		start = 1'b0;
		cycles = 0;
		while (!busy && cycles < 4)
		begin
			@(negedge clock);
			cycles++;
		end
		if (!busy)
		begin
			$display("core never went busy after start in test %s", name);
			timed_out = 1'b1;
			test_errors++;
		end
		else
		begin
			cycles = 0;
			while (!halted && cycles < halt_timeout)
			begin
				@(negedge clock);
				cycles++;
			end
			if (!halted)
			begin
				$display("core did not halt within %0d cycles in test %s",
					halt_timeout, name);
				timed_out = 1'b1;
				test_errors++;
			end
		end
	endtask

	task automatic compare_ram(string name);
		word_t got;
		for (int i = 0; i < `RAM_DEPTH; i++)
		begin
			if (track[i])
			begin
				peek(i, got);
				assert (got === m_ram[i])
				else
				begin
					$display("FAIL %s ram[0x%03h] expected 0x%02h actual 0x%02h",
						name, i, m_ram[i], got);
					test_errors++;
				end
				track[i] = 1'b0;
			end
		end
	endtask

	task automatic execute_and_check(string name);
		load_program();
		run(name);
		model_run();
		compare_ram(name);
	endtask

	task automatic finish_test(string name);
		if (test_errors == 0)
		begin
			tests_passed++;
			$display("test %-10s ok", name);
		end
		else
		begin
			tests_failed++;
			$display("test %-10s %0d errors", name, test_errors);
		end
		test_errors = 0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////////////////////
	task automatic reset_and_halt();
		assert (halted === 1'b1)
		else
		begin
			$display("FAIL reset halted expected 1 actual %b", halted);
			test_errors++;
		end
		assert (busy === 1'b0)
		else
		begin
			$display("FAIL reset busy expected 0 actual %b", busy);
			test_errors++;
		end
		prog_len = 0;
		emit(op_eop, 0, 0, 0, 0, 0);
		execute_and_check("reset");
		finish_test("reset");
	endtask

	task automatic alu_and_moves();
		prog_len = 0;
		emit(op_ldi, 0, 0, 0, 'hc8, 0);
		emit(op_ldi, 1, 0, 0, 'h64, 0);
		emit(op_add, 0, 1, 2, 0, 0);    // 300 wraps
		emit(op_sub, 1, 0, 3, 0, 0);    // borrow
		emit(op_and, 0, 1, 4, 0, 0);
		emit(op_or, 0, 1, 5, 0, 0);
		for (int r = 2; r < 6; r++)
			emit(op_store, r, 0, 0, 0, 16 + r - 2);
		emit(op_move, 2, 0, 0, 0, 0);
		emit(op_store, 0, 0, 0, 0, 20);
		emit(op_eop, 0, 0, 0, 0, 0);
		execute_and_check("alu");
		finish_test("alu");
	endtask

	task automatic shifts_and_flags();
		prog_len = 0;
		emit(op_ldi, 4, 0, 0, 'h11, 0);
		emit(op_ldi, 5, 0, 0, 'h22, 0);
		emit(op_ldi, 0, 0, 0, 'h81, 0);
		emit(op_shl, 0, 0, 0, 0, 0);    // bit 7 out
		emit(op_store, 0, 0, 0, 0, 32);
		emit_branch_check(op_bs, 33);
		emit(op_shr, 0, 0, 0, 0, 0);
		emit(op_store, 0, 0, 0, 0, 34);
		emit_branch_check(op_bs, 35);
		emit(op_shr, 0, 0, 0, 0, 0);    // zero and bit 0 out
		emit(op_store, 0, 0, 0, 0, 36);
		emit_branch_check(op_bz, 37);
		emit_branch_check(op_bs, 38);
		emit(op_ldi, 1, 0, 0, 'hf0, 0);
		emit(op_ldi, 2, 0, 0, 'h20, 0);
		emit(op_add, 1, 2, 3, 0, 0);    // carry out
		emit_branch_check(op_bc, 39);
		emit(op_add, 2, 2, 3, 0, 0);
		emit_branch_check(op_bc, 40);
		emit_branch_check(op_bz, 41);
		emit(op_eop, 0, 0, 0, 0, 0);
		execute_and_check("shift");
		finish_test("shift");
	endtask

	task automatic compare_and_branch();
		prog_len = 0;
		emit(op_ldi, 4, 0, 0, 'h33, 0);
		emit(op_ldi, 5, 0, 0, 'h44, 0);
		emit(op_ldi, 0, 0, 0, 'h50, 0);
		emit(op_ldi, 1, 0, 0, 'h30, 0);
		emit(op_cmp, 0, 1, 0, 0, 0);    // greater
		emit_branch_check(op_bg, 48);
		emit_branch_check(op_bl, 49);
		emit_branch_check(op_bz, 50);
		emit(op_cmp, 1, 0, 0, 0, 0);    // lesser
		emit_branch_check(op_bg, 51);
		emit_branch_check(op_bl, 52);
		emit(op_cmp, 0, 0, 0, 0, 0);    // equal
		emit_branch_check(op_bz, 53);
		emit_branch_check(op_bl, 54);
		emit_branch_check(op_jmp, 55);
		emit(op_eop, 0, 0, 0, 0, 0);
		execute_and_check("cmp");
		finish_test("cmp");
	endtask

	task automatic memory_round_trip();
		prog_len = 0;
		for (int i = 0; i < 8; i++)
			poke('h200 + i, word_t'(i * 37 + 200));
		emit(op_load, 0, 0, 0, 0, 'h200);
		emit(op_load, 1, 0, 0, 0, 'h201);
		emit(op_add, 0, 1, 2, 0, 0);
		emit(op_store, 2, 0, 0, 0, 'h280);
		emit(op_load, 3, 0, 0, 0, 'h202);
		emit(op_sub, 3, 0, 4, 0, 0);
		emit(op_store, 4, 0, 0, 0, 'h281);
		emit(op_eop, 0, 0, 0, 0, 0);
		execute_and_check("mem");
		finish_test("mem");
	endtask

	task automatic random_programs();
		int    len;
		int    kind;
		int    addr;
		int    ra;
		int    rb;
		int    rc;
		string name;
		for (int p = 0; p < 20 && !timed_out; p++)
		begin
			name = $sformatf("random_%0d", p);
			prog_len = 0;
			for (int a = 'h300; a < 'h320; a++)
				poke(a, word_t'($urandom()));  // loads only read this window
			len = 8 + $urandom_range(32);
			for (int i = 0; i < len; i++)
			begin
				kind = $urandom_range(10);
				addr = 'h300 + $urandom_range(31);
				ra   = $urandom_range(5);
				rb   = $urandom_range(5);
				rc   = $urandom_range(5);
				case (kind)
					0: emit(op_add, ra, rb, rc, 0, 0);
					1: emit(op_sub, ra, rb, rc, 0, 0);
					2: emit(op_and, ra, rb, rc, 0, 0);
					3: emit(op_or, ra, rb, rc, 0, 0);
					4: emit(op_shl, ra, 0, 0, 0, 0);
					5: emit(op_shr, ra, 0, 0, 0, 0);
					6: emit(op_cmp, ra, rb, 0, 0, 0);
					7: emit(op_move, ra, rb, 0, 0, 0);
					8: emit(op_ldi, ra, 0, 0, $urandom_range(255), 0);
					9: emit(op_load, ra, 0, 0, 0, addr);
					default: emit(op_store, ra, 0, 0, 0, addr);
				endcase
			end
			for (int r = 0; r < `REG_COUNT; r++)
				emit(op_store, r, 0, 0, 0, 'h320 + r);  // dump every register
			emit(op_eop, 0, 0, 0, 0, 0);
			execute_and_check(name);
			finish_test(name);
		end
	endtask

	initial
	begin
		clock        = 1'b0;
		reset        = 1'b1;
		start        = 1'b0;
		prog_we      = 1'b0;
		prog_addr    = '0;
		prog_wdata   = '0;
		host_we      = 1'b0;
		host_addr    = '0;
		host_wdata   = '0;
		prog_len     = 0;
		test_errors  = 0;
		tests_passed = 0;
		tests_failed = 0;
		timed_out    = 1'b0;
		void'($urandom(14));
		for (int r = 0; r < `REG_COUNT; r++)
			m_regs[r] = '0;
		repeat (16) @(negedge clock);
		reset = 1'b0;
		for (int t = 0; t < 6 && !timed_out; t++)
		begin
			case (t)
				0: reset_and_halt();
				1: alu_and_moves();
				2: shifts_and_flags();
				3: compare_and_branch();
				4: memory_round_trip();
				default: random_programs();
			endcase
		end
		$display("tests passed %0d, failed %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && !timed_out)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* build.f */
+incdir+.
cpu_pkg.sv
dual_port_ram.sv
register_file.sv
alu.sv
sequencer.sv
cpu_top.sv
cpu_tb.sv
